//--- hw/rv_isa_pkg.sv
// RV64 encodings used by the execute half only; branch, system and fence ops are not encoded here
`default_nettype none

package rv_isa_pkg;

  localparam int WORD_WD = 64;

  typedef logic [WORD_WD-1:0] word_t;
  typedef logic [63:0]        addr_t;  // pc

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_SRC2 = 4'd10   // lui
  } alu_op_e;

  // bit 2 picks the zimm source as in funct3
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_W    = 3'd1,
    CSR_S    = 3'd2,
    CSR_C    = 3'd3,
    CSR_WI   = 3'd5,
    CSR_SI   = 3'd6,
    CSR_CI   = 3'd7
  } csr_op_e;

  // stores use only the signed load codes
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
// pipeline widths for a 32-bit byte-addressed data SRAM of 2**DMEM_DEPTH_LOG2 double-words
`default_nettype none

package pipe_pkg;

  localparam int DMEM_DEPTH_LOG2 = 8;  // in double-words

  typedef logic [4:0]  gpr_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] sram_addr_t;
  typedef logic [7:0]  sram_wmask_t;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2   // link address
  } src2_sel_e;

endpackage

`default_nettype wire

//--- hw/exu.sv
// purely combinational; src1_sel high picks pc, zimm is taken from imm[4:0]
`timescale 1ns/100ps
`default_nettype none

module exu
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  word_t     i_rs1data,
  input  word_t     i_rs2data,
  input  word_t     i_imm,
  input  word_t     i_csrrdata,
  input  addr_t     i_pc,
  input  logic      i_alu_src1_sel,
  input  src2_sel_e i_alu_src2_sel,
  input  alu_op_e   i_alu_op,
  input  logic      i_alu_word_cut_sel,
  input  csr_op_e   i_csr_op,
  output word_t     o_alu_result,
  output word_t     o_csr_result
);

  word_t      src1;
  word_t      src2;
  word_t      shift_src;
  word_t      alu_raw;
  word_t      csr_opnd;
  logic [5:0] shamt;

  always_comb begin
    src1 = i_alu_src1_sel ? i_pc : i_rs1data;
    case (i_alu_src2_sel)
      SRC2_IMM:  src2 = i_imm;
      SRC2_FOUR: src2 = 64'd4;
      default:   src2 = i_rs2data;
    endcase
  end

  // w-type shifts see only the low word of src1
  assign shamt = i_alu_word_cut_sel ? {1'b0, src2[4:0]} : src2[5:0];

  always_comb begin
    if (!i_alu_word_cut_sel) begin
      shift_src = src1;
    end else if (i_alu_op == ALU_SRA) begin
      shift_src = {{32{src1[31]}}, src1[31:0]};
    end else begin
      shift_src = {32'd0, src1[31:0]};
    end
  end

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  alu_raw = src1 + src2;
      ALU_SUB:  alu_raw = src1 - src2;
      ALU_SLL:  alu_raw = src1 << shamt;
      ALU_SLT:  alu_raw = {63'd0, $signed(src1) < $signed(src2)};
      ALU_SLTU: alu_raw = {63'd0, src1 < src2};
      ALU_XOR:  alu_raw = src1 ^ src2;
      ALU_SRL:  alu_raw = shift_src >> shamt;
      ALU_SRA:  alu_raw = $signed(shift_src) >>> shamt;
      ALU_OR:   alu_raw = src1 | src2;
      ALU_AND:  alu_raw = src1 & src2;
      ALU_SRC2: alu_raw = src2;
      default:  alu_raw = '0;
    endcase
  end

  assign o_alu_result = i_alu_word_cut_sel ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign csr_opnd = i_csr_op[2] ? {59'd0, i_imm[4:0]} : i_rs1data;

  always_comb begin
    case (i_csr_op)
      CSR_W, CSR_WI: o_csr_result = csr_opnd;
      CSR_S, CSR_SI: o_csr_result = i_csrrdata | csr_opnd;
      CSR_C, CSR_CI: o_csr_result = i_csrrdata & ~csr_opnd;
      default:       o_csr_result = i_csrrdata;  // unchanged
    endcase
  end

endmodule

`default_nettype wire

//--- hw/lsu_store.sv
// store lanes only; misaligned addresses are not split and are flagged in ex_stage
`timescale 1ns/100ps
`default_nettype none

module lsu_store
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  mem_op_e     i_mem_op,
  input  logic [2:0]  i_waddr_align,
  input  word_t       i_wdata,
  output sram_wmask_t o_wmask,
  output word_t       o_wdata
);

  always_comb begin
    case (i_mem_op)
      MEM_B, MEM_BU: begin
        o_wdata = {8{i_wdata[7:0]}};
        o_wmask = 8'h01 << i_waddr_align;
      end
      MEM_H, MEM_HU: begin
        o_wdata = {4{i_wdata[15:0]}};
        o_wmask = 8'h03 << i_waddr_align;
      end
      MEM_W, MEM_WU: begin
        o_wdata = {2{i_wdata[31:0]}};
        o_wmask = 8'h0f << i_waddr_align;
      end
      default: begin
        o_wdata = i_wdata;
        o_wmask = 8'hff;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/lsu_load.sv
// expects the whole aligned double-word from the SRAM and a naturally aligned offset
`timescale 1ns/100ps
`default_nettype none

module lsu_load
  import rv_isa_pkg::*;
(
  input  mem_op_e    i_mem_op,
  input  logic [2:0] i_raddr_align,
  input  word_t      i_rdata,
  output word_t      o_rdata
);

  word_t lane;

  assign lane = i_rdata >> {i_raddr_align, 3'b000};  // addressed byte to bit 0

  always_comb begin
    case (i_mem_op)
      MEM_B:   o_rdata = {{56{lane[7]}}, lane[7:0]};
      MEM_H:   o_rdata = {{48{lane[15]}}, lane[15:0]};
      MEM_W:   o_rdata = {{32{lane[31]}}, lane[31:0]};
      MEM_BU:  o_rdata = {56'd0, lane[7:0]};
      MEM_HU:  o_rdata = {48'd0, lane[15:0]};
      MEM_WU:  o_rdata = {32'd0, lane[31:0]};
      default: o_rdata = lane;  // ld
    endcase
  end

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
// single-cycle execute; one SRAM request per item, sent only in the cycle it moves to mem_stage
`timescale 1ns/100ps
`default_nettype none

module ex_stage
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  // from decode
  input  logic        i_ds_valid,
  output logic        o_es_allowin,
  input  word_t       i_rs1data,
  input  word_t       i_rs2data,
  input  word_t       i_csrrdata,
  input  word_t       i_imm,
  input  addr_t       i_pc,
  input  logic        i_alu_src1_sel,
  input  src2_sel_e   i_alu_src2_sel,
  input  alu_op_e     i_alu_op,
  input  logic        i_alu_word_cut_sel,
  input  gpr_addr_t   i_rd,
  input  csr_addr_t   i_csr,
  input  logic        i_gpr_wen,
  input  logic        i_csr_wen,
  input  logic        i_mem_ren,
  input  logic        i_mem_wen,
  input  mem_op_e     i_mem_op,
  input  logic        i_csr_inst_sel,
  input  csr_op_e     i_csr_op,
  // to mem stage
  input  logic        i_ms_allowin,
  output logic        o_es_to_ms_valid,
  output gpr_addr_t   o_es_rd,
  output logic        o_es_gpr_wen,
  output csr_addr_t   o_es_csr,
  output logic        o_es_csr_wen,
  output logic        o_es_mem_ren,
  output mem_op_e     o_es_mem_op,
  output logic        o_es_csr_inst_sel,
  output word_t       o_es_csrrdata,
  output word_t       o_es_alu_result,
  output word_t       o_es_csr_result,
  // data sram
  output sram_addr_t  o_data_sram_addr,
  output logic        o_data_sram_ren,
  output logic        o_data_sram_wen,
  output sram_wmask_t o_data_sram_wmask,
  output word_t       o_data_sram_wdata,
  // hazard check
  output gpr_addr_t   o_es_gpr_rd,
  output csr_addr_t   o_es_csr_rd
);

  logic      es_valid;
  logic      es_xfer;
  logic      es_misalign;
  word_t     es_rs1data;
  word_t     es_rs2data;
  word_t     es_csrrdata;
  word_t     es_imm;
  addr_t     es_pc;
  logic      es_alu_src1_sel;
  src2_sel_e es_alu_src2_sel;
  alu_op_e   es_alu_op;
  logic      es_alu_word_cut_sel;
  gpr_addr_t es_rd;
  csr_addr_t es_csr;
  logic      es_gpr_wen;
  logic      es_csr_wen;
  logic      es_mem_ren;
  logic      es_mem_wen;
  mem_op_e   es_mem_op;
  logic      es_csr_inst_sel;
  csr_op_e   es_csr_op;

  // ready_go is always high here
  assign o_es_allowin     = !es_valid || i_ms_allowin;
  assign o_es_to_ms_valid = es_valid;
  assign es_xfer          = es_valid && i_ms_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_valid && o_es_allowin) begin
      es_rs1data          <= i_rs1data;
      es_rs2data          <= i_rs2data;
      es_csrrdata         <= i_csrrdata;
      es_imm              <= i_imm;
      es_pc               <= i_pc;
      es_alu_src1_sel     <= i_alu_src1_sel;
      es_alu_src2_sel     <= i_alu_src2_sel;
      es_alu_op           <= i_alu_op;
      es_alu_word_cut_sel <= i_alu_word_cut_sel;
      es_rd               <= i_rd;
      es_csr              <= i_csr;
      es_gpr_wen          <= i_gpr_wen;
      es_csr_wen          <= i_csr_wen;
      es_mem_ren          <= i_mem_ren;
      es_mem_wen          <= i_mem_wen;
      es_mem_op           <= i_mem_op;
      es_csr_inst_sel     <= i_csr_inst_sel;
      es_csr_op           <= i_csr_op;
    end
  end

  exu u_exu (
    .i_rs1data          (es_rs1data),
    .i_rs2data          (es_rs2data),
    .i_imm              (es_imm),
    .i_csrrdata         (es_csrrdata),
    .i_pc               (es_pc),
    .i_alu_src1_sel     (es_alu_src1_sel),
    .i_alu_src2_sel     (es_alu_src2_sel),
    .i_alu_op           (es_alu_op),
    .i_alu_word_cut_sel (es_alu_word_cut_sel),
    .i_csr_op           (es_csr_op),
    .o_alu_result       (o_es_alu_result),
    .o_csr_result       (o_es_csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op      (es_mem_op),
    .i_waddr_align (o_es_alu_result[2:0]),  // rs1 + imm
    .i_wdata       (es_rs2data),
    .o_wmask       (o_data_sram_wmask),
    .o_wdata       (o_data_sram_wdata)
  );

  assign o_es_rd           = es_rd;
  assign o_es_gpr_wen      = es_gpr_wen;
  assign o_es_csr          = es_csr;
  assign o_es_csr_wen      = es_csr_wen;
  assign o_es_mem_ren      = es_mem_ren;
  assign o_es_mem_op       = es_mem_op;
  assign o_es_csr_inst_sel = es_csr_inst_sel;
  assign o_es_csrrdata     = es_csrrdata;

  // a stalled item must not re-issue
  assign o_data_sram_addr = o_es_alu_result[31:0];
  assign o_data_sram_ren  = es_xfer && es_mem_ren;
  assign o_data_sram_wen  = es_xfer && es_mem_wen;

  assign o_es_gpr_rd = (es_valid && es_gpr_wen) ? es_rd : '0;
  assign o_es_csr_rd = (es_valid && es_csr_wen) ? es_csr : '0;

  always_comb begin
    case (es_mem_op)
      MEM_H, MEM_HU: es_misalign = o_es_alu_result[0];
      MEM_W, MEM_WU: es_misalign = |o_es_alu_result[1:0];
      MEM_D:         es_misalign = |o_es_alu_result[2:0];
      default:       es_misalign = 1'b0;
    endcase
  end

  // decoder never marks an op as both load and store
  a_no_ren_wen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_data_sram_ren && o_data_sram_wen));

  // lsu lanes assume natural alignment
  a_mem_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_data_sram_ren || o_data_sram_wen) |-> !es_misalign);

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
// relies on the SRAM returning read data exactly one cycle after the request
`timescale 1ns/100ps
`default_nettype none

module mem_stage
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  // from ex stage
  input  logic      i_es_to_ms_valid,
  output logic      o_ms_allowin,
  input  gpr_addr_t i_es_rd,
  input  logic      i_es_gpr_wen,
  input  csr_addr_t i_es_csr,
  input  logic      i_es_csr_wen,
  input  logic      i_es_mem_ren,
  input  mem_op_e   i_es_mem_op,
  input  logic      i_es_csr_inst_sel,
  input  word_t     i_es_csrrdata,
  input  word_t     i_es_alu_result,
  input  word_t     i_es_csr_result,
  input  word_t     i_data_sram_rdata,
  // writeback
  input  logic      i_wb_allowin,
  output logic      o_wb_valid,
  output gpr_addr_t o_wb_rd,
  output logic      o_wb_gpr_wen,
  output word_t     o_wb_gpr_wdata,
  output csr_addr_t o_wb_csr,
  output logic      o_wb_csr_wen,
  output word_t     o_wb_csr_wdata,
  output gpr_addr_t o_ms_gpr_rd
);

  logic      ms_valid;
  logic      ms_fresh;    // first cycle in stage with sram data on the bus
  logic      ms_ready_go;
  logic      ms_entry;
  gpr_addr_t ms_rd;
  logic      ms_gpr_wen;
  csr_addr_t ms_csr;
  logic      ms_csr_wen;
  logic      ms_mem_ren;
  mem_op_e   ms_mem_op;
  logic      ms_csr_inst_sel;
  word_t     ms_csrrdata;
  word_t     ms_alu_result;
  word_t     ms_csr_result;
  word_t     ms_ld_data;
  word_t     ms_gpr_wdata;

  assign ms_ready_go  = !ms_fresh;
  assign o_ms_allowin = !ms_valid || (ms_ready_go && i_wb_allowin);
  assign ms_entry     = i_es_to_ms_valid && o_ms_allowin;
  assign o_wb_valid   = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
      ms_fresh <= 1'b0;
    end else begin
      if (o_ms_allowin) begin
        ms_valid <= i_es_to_ms_valid;
      end
      ms_fresh <= ms_entry;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ms_entry) begin
      ms_rd           <= i_es_rd;
      ms_gpr_wen      <= i_es_gpr_wen;
      ms_csr          <= i_es_csr;
      ms_csr_wen      <= i_es_csr_wen;
      ms_mem_ren      <= i_es_mem_ren;
      ms_mem_op       <= i_es_mem_op;
      ms_csr_inst_sel <= i_es_csr_inst_sel;
      ms_csrrdata     <= i_es_csrrdata;
      ms_alu_result   <= i_es_alu_result;
      ms_csr_result   <= i_es_csr_result;
    end
  end

  lsu_load u_lsu_load (
    .i_mem_op      (ms_mem_op),
    .i_raddr_align (ms_alu_result[2:0]),
    .i_rdata       (i_data_sram_rdata),
    .o_rdata       (ms_ld_data)
  );

  // later cycles keep this copy since sram output may change under a stall
  always_ff @(posedge i_clk) begin
    if (ms_fresh) begin
      if (ms_mem_ren) begin
        ms_gpr_wdata <= ms_ld_data;
      end else if (ms_csr_inst_sel) begin
        ms_gpr_wdata <= ms_csrrdata;  // old csr value to rd
      end else begin
        ms_gpr_wdata <= ms_alu_result;
      end
    end
  end

  assign o_wb_rd        = ms_rd;
  assign o_wb_gpr_wen   = ms_gpr_wen;
  assign o_wb_gpr_wdata = ms_gpr_wdata;
  assign o_wb_csr       = ms_csr;
  assign o_wb_csr_wen   = ms_csr_wen;
  assign o_wb_csr_wdata = ms_csr_result;
  assign o_ms_gpr_rd    = (ms_valid && ms_gpr_wen) ? ms_rd : '0;

  a_wb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_wb_valid && !i_wb_allowin) |=> (o_wb_valid && $stable(o_wb_gpr_wdata)));

endmodule

`default_nettype wire

//--- hw/data_sram.sv
// address bits above the memory depth are ignored, so accesses wrap; contents start at zero
`timescale 1ns/100ps
`default_nettype none

module data_sram
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        i_clk,
  input  sram_addr_t  i_addr,
  input  logic        i_ren,
  input  logic        i_wen,
  input  sram_wmask_t i_wmask,
  input  word_t       i_wdata,
  output word_t       o_rdata
);

  word_t                      mem [2**DMEM_DEPTH_LOG2];
  logic [DMEM_DEPTH_LOG2-1:0] idx;

  assign idx = i_addr[DMEM_DEPTH_LOG2+2:3];  // double-word index

  initial begin
    for (int i = 0; i < 2**DMEM_DEPTH_LOG2; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b]) mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
      end
    end
    if (i_ren) begin
      o_rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

//--- hw/ex_mem_top.sv
// execute and memory stages with their data memory; csr hazard address is not brought out
`timescale 1ns/100ps
`default_nettype none

module ex_mem_top
  import rv_isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_ds_valid,
  output logic      o_es_allowin,
  input  word_t     i_rs1data,
  input  word_t     i_rs2data,
  input  word_t     i_csrrdata,
  input  word_t     i_imm,
  input  addr_t     i_pc,
  input  logic      i_alu_src1_sel,
  input  src2_sel_e i_alu_src2_sel,
  input  alu_op_e   i_alu_op,
  input  logic      i_alu_word_cut_sel,
  input  gpr_addr_t i_rd,
  input  csr_addr_t i_csr,
  input  logic      i_gpr_wen,
  input  logic      i_csr_wen,
  input  logic      i_mem_ren,
  input  logic      i_mem_wen,
  input  mem_op_e   i_mem_op,
  input  logic      i_csr_inst_sel,
  input  csr_op_e   i_csr_op,
  input  logic      i_wb_allowin,
  output logic      o_wb_valid,
  output gpr_addr_t o_wb_rd,
  output logic      o_wb_gpr_wen,
  output word_t     o_wb_gpr_wdata,
  output csr_addr_t o_wb_csr,
  output logic      o_wb_csr_wen,
  output word_t     o_wb_csr_wdata,
  output gpr_addr_t o_es_gpr_rd,
  output gpr_addr_t o_ms_gpr_rd
);

  logic        es_to_ms_valid;
  logic        ms_allowin;
  gpr_addr_t   es_rd;
  logic        es_gpr_wen;
  csr_addr_t   es_csr;
  logic        es_csr_wen;
  logic        es_mem_ren;
  mem_op_e     es_mem_op;
  logic        es_csr_inst_sel;
  word_t       es_csrrdata;
  word_t       es_alu_result;
  word_t       es_csr_result;
  sram_addr_t  sram_addr;
  logic        sram_ren;
  logic        sram_wen;
  sram_wmask_t sram_wmask;
  word_t       sram_wdata;
  word_t       sram_rdata;

  ex_stage u_ex_stage (
    .i_clk, .i_rst_n, .i_ds_valid, .o_es_allowin,
    .i_rs1data, .i_rs2data, .i_csrrdata, .i_imm, .i_pc,
    .i_alu_src1_sel, .i_alu_src2_sel, .i_alu_op, .i_alu_word_cut_sel,
    .i_rd, .i_csr, .i_gpr_wen, .i_csr_wen, .i_mem_ren, .i_mem_wen,
    .i_mem_op, .i_csr_inst_sel, .i_csr_op,
    .i_ms_allowin      (ms_allowin),
    .o_es_to_ms_valid  (es_to_ms_valid),
    .o_es_rd           (es_rd),
    .o_es_gpr_wen      (es_gpr_wen),
    .o_es_csr          (es_csr),
    .o_es_csr_wen      (es_csr_wen),
    .o_es_mem_ren      (es_mem_ren),
    .o_es_mem_op       (es_mem_op),
    .o_es_csr_inst_sel (es_csr_inst_sel),
    .o_es_csrrdata     (es_csrrdata),
    .o_es_alu_result   (es_alu_result),
    .o_es_csr_result   (es_csr_result),
    .o_data_sram_addr  (sram_addr),
    .o_data_sram_ren   (sram_ren),
    .o_data_sram_wen   (sram_wen),
    .o_data_sram_wmask (sram_wmask),
    .o_data_sram_wdata (sram_wdata),
    .o_es_gpr_rd,
    .o_es_csr_rd       ()
  );

  mem_stage u_mem_stage (
    .i_clk, .i_rst_n,
    .i_es_to_ms_valid  (es_to_ms_valid),
    .o_ms_allowin      (ms_allowin),
    .i_es_rd           (es_rd),
    .i_es_gpr_wen      (es_gpr_wen),
    .i_es_csr          (es_csr),
    .i_es_csr_wen      (es_csr_wen),
    .i_es_mem_ren      (es_mem_ren),
    .i_es_mem_op       (es_mem_op),
    .i_es_csr_inst_sel (es_csr_inst_sel),
    .i_es_csrrdata     (es_csrrdata),
    .i_es_alu_result   (es_alu_result),
    .i_es_csr_result   (es_csr_result),
    .i_data_sram_rdata (sram_rdata),
    .i_wb_allowin, .o_wb_valid, .o_wb_rd, .o_wb_gpr_wen, .o_wb_gpr_wdata,
    .o_wb_csr, .o_wb_csr_wen, .o_wb_csr_wdata, .o_ms_gpr_rd
  );

  data_sram u_data_sram (
    .i_clk,
    .i_addr  (sram_addr),
    .i_ren   (sram_ren),
    .i_wen   (sram_wen),
    .i_wmask (sram_wmask),
    .i_wdata (sram_wdata),
    .o_rdata (sram_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/ex_mem_checker.sv
// follows the valid/allowin rules with its own stage model; assumes records enter in file order
`timescale 1ns/100ps
`default_nettype none

module ex_mem_checker
  import rv_isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int NUM_REC = 1
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_ds_valid,
  input  logic      i_es_allowin,
  input  logic      i_wb_allowin,
  input  logic      i_wb_valid,
  input  gpr_addr_t i_wb_rd,
  input  logic      i_wb_gpr_wen,
  input  word_t     i_wb_gpr_wdata,
  input  csr_addr_t i_wb_csr,
  input  logic      i_wb_csr_wen,
  input  word_t     i_wb_csr_wdata,
  input  gpr_addr_t i_es_gpr_rd,
  input  gpr_addr_t i_ms_gpr_rd,
  output logic      o_done,
  output int        o_rec_count,
  output int        o_err_count
);

  word_t     recs [NUM_REC*8];
  int        err_count = 0;
  int        rec_count = 0;  // written back
  int        acc_count = 0;  // accepted by ex
  int        es_idx = 0;
  int        ms_idx = 0;
  logic      es_v = 1'b0;
  logic      ms_v = 1'b0;
  logic      ms_new = 1'b0;  // first cycle in mem with no wb yet
  logic      exp_wb_valid;
  logic      exp_es_allowin;
  logic      ms_allow;
  logic      es_xfer;
  gpr_addr_t exp_es_rd;
  gpr_addr_t exp_ms_rd;

  initial begin
    $readmemh("testbench/ex_testdata.mem", recs);
  end

  assign o_done      = (rec_count == NUM_REC);
  assign o_rec_count = rec_count;
  assign o_err_count = err_count;

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_count++;
  endtask

  function automatic gpr_addr_t rd_if_writing(input int n);
    word_t ctrl;
    ctrl = recs[8*n];
    return ctrl[24] ? ctrl[36:32] : '0;
  endfunction

  task automatic check_writeback(input int n);
    word_t     ctrl;
    gpr_addr_t exp_rd;
    int        bad;
    ctrl   = recs[8*n];
    exp_rd = ctrl[36:32];
    bad    = 0;
    if (i_wb_rd !== exp_rd) begin
      flag_error($sformatf("record %0d rd %0d, expected %0d", n, i_wb_rd, exp_rd));
      bad++;
    end
    if (i_wb_gpr_wen !== ctrl[24] || i_wb_csr_wen !== ctrl[25]) begin
      flag_error($sformatf("record %0d gpr/csr wen %b%b, expected %b%b", n,
                           i_wb_gpr_wen, i_wb_csr_wen, ctrl[24], ctrl[25]));
      bad++;
    end
    if (ctrl[24] && i_wb_gpr_wdata !== recs[8*n+6]) begin
      flag_error($sformatf("record %0d gpr data %h, expected %h", n,
                           i_wb_gpr_wdata, recs[8*n+6]));
      bad++;
    end
    if (ctrl[25] && (i_wb_csr !== ctrl[51:40] || i_wb_csr_wdata !== recs[8*n+7])) begin
      flag_error($sformatf("record %0d csr %h data %h, expected %h data %h", n,
                           i_wb_csr, i_wb_csr_wdata, ctrl[51:40], recs[8*n+7]));
      bad++;
    end
    $display("record %0d rd %0d: %s", n, exp_rd, (bad == 0) ? "ok" : "mismatch");
  endtask

  // inputs change 1 ns after posedge, so negedge sees what the next edge will use
  always @(negedge i_clk) begin
    if (!i_rst_n) begin
      es_v   = 1'b0;
      ms_v   = 1'b0;
      ms_new = 1'b0;
      if (i_wb_valid !== 1'b0) flag_error("o_wb_valid high during reset");
    end else begin
      exp_wb_valid   = ms_v && !ms_new;
      ms_allow       = !ms_v || (exp_wb_valid && i_wb_allowin);
      exp_es_allowin = !es_v || ms_allow;
      es_xfer        = es_v && ms_allow;
      exp_es_rd      = '0;
      exp_ms_rd      = '0;
      if (es_v) exp_es_rd = rd_if_writing(es_idx);
      if (ms_v) exp_ms_rd = rd_if_writing(ms_idx);
      if (i_wb_valid !== exp_wb_valid) begin
        flag_error($sformatf("o_wb_valid %b, expected %b", i_wb_valid, exp_wb_valid));
      end
      if (i_es_allowin !== exp_es_allowin) begin
        flag_error($sformatf("o_es_allowin %b, expected %b", i_es_allowin, exp_es_allowin));
      end
      if (i_es_gpr_rd !== exp_es_rd || i_ms_gpr_rd !== exp_ms_rd) begin
        flag_error($sformatf("hazard rd es %0d ms %0d, expected %0d %0d",
                             i_es_gpr_rd, i_ms_gpr_rd, exp_es_rd, exp_ms_rd));
      end
      if (exp_wb_valid && i_wb_allowin) begin
        check_writeback(ms_idx);
        rec_count++;
      end
      // step the model past the coming edge
      if (ms_allow) begin
        ms_v   = es_v;
        ms_idx = es_idx;
      end
      ms_new = es_xfer;
      if (exp_es_allowin) begin
        es_v   = i_ds_valid;
        es_idx = acc_count;
        if (i_ds_valid) acc_count++;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_ex_mem.sv
// run from the project root so the data file path resolves; NUM_REC must match the data file
`timescale 1ns/100ps
`default_nettype none

module tb_ex_mem
  import rv_isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int NUM_REC    = 36;
  localparam int RST_CYCLES = 4;
  localparam int MAX_CYCLES = NUM_REC * 12 + RST_CYCLES;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      ds_valid;
  logic      es_allowin;
  word_t     rs1data;
  word_t     rs2data;
  word_t     csrrdata;
  word_t     imm;
  addr_t     pc;
  logic      alu_src1_sel;
  src2_sel_e alu_src2_sel;
  alu_op_e   alu_op;
  logic      alu_word_cut_sel;
  gpr_addr_t rd;
  csr_addr_t csr;
  logic      gpr_wen;
  logic      csr_wen;
  logic      mem_ren;
  logic      mem_wen;
  mem_op_e   mem_op;
  logic      csr_inst_sel;
  csr_op_e   csr_op;
  logic      wb_allowin;
  logic      wb_valid;
  gpr_addr_t wb_rd;
  logic      wb_gpr_wen;
  word_t     wb_gpr_wdata;
  csr_addr_t wb_csr;
  logic      wb_csr_wen;
  word_t     wb_csr_wdata;
  gpr_addr_t es_gpr_rd;
  gpr_addr_t ms_gpr_rd;
  logic      chk_done;
  int        rec_count;
  int        err_count;
  int        cycle_count = 0;

  word_t recs [NUM_REC*8];  // eight words per record

  ex_mem_top uut (
    .i_clk (clk), .i_rst_n (rst_n), .i_ds_valid (ds_valid), .o_es_allowin (es_allowin),
    .i_rs1data (rs1data), .i_rs2data (rs2data), .i_csrrdata (csrrdata), .i_imm (imm),
    .i_pc (pc), .i_alu_src1_sel (alu_src1_sel), .i_alu_src2_sel (alu_src2_sel),
    .i_alu_op (alu_op), .i_alu_word_cut_sel (alu_word_cut_sel), .i_rd (rd), .i_csr (csr),
    .i_gpr_wen (gpr_wen), .i_csr_wen (csr_wen), .i_mem_ren (mem_ren), .i_mem_wen (mem_wen),
    .i_mem_op (mem_op), .i_csr_inst_sel (csr_inst_sel), .i_csr_op (csr_op),
    .i_wb_allowin (wb_allowin), .o_wb_valid (wb_valid), .o_wb_rd (wb_rd),
    .o_wb_gpr_wen (wb_gpr_wen), .o_wb_gpr_wdata (wb_gpr_wdata), .o_wb_csr (wb_csr),
    .o_wb_csr_wen (wb_csr_wen), .o_wb_csr_wdata (wb_csr_wdata),
    .o_es_gpr_rd (es_gpr_rd), .o_ms_gpr_rd (ms_gpr_rd)
  );

  ex_mem_checker #(.NUM_REC (NUM_REC)) u_checker (
    .i_clk (clk), .i_rst_n (rst_n), .i_ds_valid (ds_valid), .i_es_allowin (es_allowin),
    .i_wb_allowin (wb_allowin), .i_wb_valid (wb_valid), .i_wb_rd (wb_rd),
    .i_wb_gpr_wen (wb_gpr_wen), .i_wb_gpr_wdata (wb_gpr_wdata), .i_wb_csr (wb_csr),
    .i_wb_csr_wen (wb_csr_wen), .i_wb_csr_wdata (wb_csr_wdata),
    .i_es_gpr_rd (es_gpr_rd), .i_ms_gpr_rd (ms_gpr_rd),
    .o_done (chk_done), .o_rec_count (rec_count), .o_err_count (err_count)
  );

  always #2 clk = ~clk;

  initial begin
    $readmemh("testbench/ex_testdata.mem", recs);
  end

  task automatic drive_record(input int n);
    word_t ctrl;
    ctrl             = recs[8*n];
    alu_op           = alu_op_e'(ctrl[3:0]);
    alu_src2_sel     = src2_sel_e'(ctrl[5:4]);
    alu_src1_sel     = ctrl[8];
    alu_word_cut_sel = ctrl[12];
    mem_op           = mem_op_e'(ctrl[18:16]);
    csr_op           = csr_op_e'(ctrl[22:20]);
    gpr_wen          = ctrl[24];
    csr_wen          = ctrl[25];
    mem_ren          = ctrl[26];
    mem_wen          = ctrl[27];
    csr_inst_sel     = ctrl[28];
    rd               = ctrl[36:32];
    csr              = ctrl[51:40];
    rs1data          = recs[8*n+1];
    rs2data          = recs[8*n+2];
    imm              = recs[8*n+3];
    pc               = recs[8*n+4];
    csrrdata         = recs[8*n+5];
    ds_valid         = 1'b1;
  endtask

  // sink stalls about one cycle in three
  always @(posedge clk) begin
    #1;
    wb_allowin = ($urandom % 3) != 0;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: only %0d of %0d records written back after %0d cycles",
               rec_count, NUM_REC, cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    void'($urandom(92215));
    rst_n            = 1'b0;
    ds_valid         = 1'b0;
    rs1data          = '0;
    rs2data          = '0;
    csrrdata         = '0;
    imm              = '0;
    pc               = '0;
    alu_src1_sel     = 1'b0;
    alu_src2_sel     = SRC2_RS2;
    alu_op           = ALU_ADD;
    alu_word_cut_sel = 1'b0;
    rd               = '0;
    csr              = '0;
    gpr_wen          = 1'b0;
    csr_wen          = 1'b0;
    mem_ren          = 1'b0;
    mem_wen          = 1'b0;
    mem_op           = MEM_B;
    csr_inst_sel     = 1'b0;
    csr_op           = CSR_NONE;
    wb_allowin       = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < NUM_REC; n++) begin
      drive_record(n);
      do @(negedge clk); while (!es_allowin);  // held until taken
      @(posedge clk);
      #1;
    end
    ds_valid = 1'b0;
    wait (chk_done);
    @(negedge clk);
    $display("summary: %0d of %0d records checked, %0d errors", rec_count, NUM_REC, err_count);
    if (err_count == 0 && rec_count == NUM_REC) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/ex_testdata.mem
// ctrl rs1 rs2 imm pc csrrdata exp_gpr exp_csr (exp fields only count when the wen is set)
// ctrl hex hi..lo: csr(3) rd(2) csr_inst_sel flags(1 gpr 2 csr 4 ren 8 wen) csr_op mem_op wcut src1 src2 alu_op
0000101000000 10 20 0 0 0 30 0
0000201000001 5 7 0 0 0 fffffffffffffffe 0
0000301000002 1 3f 0 0 0 8000000000000000 0
0000401000003 ffffffffffffffff 1 0 0 0 1 0
0000501000004 ffffffffffffffff 1 0 0 0 0 0
0000601000007 8000000000000000 4 0 0 0 f800000000000000 0
0000701001006 ffffffff80000000 24 0 0 0 8000000 0
0000801001007 80000000 4 0 0 0 fffffffff8000000 0
0000901001010 7fffffff 0 1 0 0 ffffffff80000000 0
0000a0100001a 55 0 12345000 0 0 12345000 0
0000b01000120 0 0 0 80000010 0 80000014 0
0000c01000009 f0f0 ff00 0 0 0 f000 0
0000d01000005 ff0 ff 0 0 0 f0f 0
0000e01000008 f00 f0 0 0 0 ff0 0
3400f13100000 1234 0 0 0 aa aa 1234
3001013200000 f 0 0 0 f0 f0 ff
3041113300000 f 0 0 0 ff ff f0
3051213500000 9999 0 1f 0 8 8 1f
3411313600000 0 0 5 0 10 10 15
3421413700000 0 0 3 0 ff ff fc
0000008030010 100 f1e2d3c4b5a69788 0 0 0 0 0
0000008000010 108 ffffffffffffff5a 3 0 0 0 0
0000008010010 108 12348001 4 0 0 0 0
0000008020010 110 89abcdef 4 0 0 0 0
0001505000010 100 0 1 0 0 ffffffffffffff97 0
0001605040010 100 0 7 0 0 f1 0
0001705010010 100 0 6 0 0 fffffffffffff1e2 0
0001805050010 100 0 2 0 0 b5a6 0
0001905020010 100 0 4 0 0 fffffffff1e2d3c4 0
0001a05060010 100 0 0 0 0 b5a69788 0
0001b05030010 100 0 0 0 0 f1e2d3c4b5a69788 0
0001c05000010 108 0 3 0 0 5a 0
0001d05010010 108 0 4 0 0 ffffffffffff8001 0
0001e05030010 108 0 0 0 0 80015a000000 0
0001f05020010 110 0 4 0 0 ffffffff89abcdef 0
0000105030010 118 0 fffffffffffffff8 0 0 89abcdef00000000 0

//--- list.f
hw/rv_isa_pkg.sv
hw/pipe_pkg.sv
hw/exu.sv
hw/lsu_store.sv
hw/lsu_load.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/data_sram.sv
hw/ex_mem_top.sv
testbench/ex_mem_checker.sv
testbench/tb_ex_mem.sv

//--- run.sh
#!/bin/sh
# compile and run the ex/mem testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ex_mem -Mdir obj_dir -o sim_ex_mem -f list.f
out=$(./obj_dir/sim_ex_mem) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
